/* verilog.f */
+incdir+.
signal_router_pkg.sv
sys_reg_bank.sv
source_mux.sv
slow_dac_scaler.sv
trigger_select.sv
signal_router_top.sv
tb_signal_router.sv

/* Bender.yml */
package:
  name: signal_router

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - signal_router_pkg.sv
      - sys_reg_bank.sv
      - source_mux.sv
      - slow_dac_scaler.sv
      - trigger_select.sv
      - signal_router_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_signal_router.sv

/* tb_signal_router.sv */
`default_nettype none

`include "signal_router_cfg.svh"

module tb_signal_router;

    timeunit 1ns;
    timeprecision 1ps;

    import signal_router_pkg::*;

    localparam int N_RANDOM     = 3000;
    localparam int TOTAL_CYCLES = 2 + 8 + N_RANDOM + 1;  // reset, reset reads, random, last check

    logic       clk;
    logic       rst;
    sample_t    in1;
    sample_t    in2;
    logic       ext_trig;
    sys_req_t   req;
    sys_rsp_t   rsp;
    sample_t    out1;
    sample_t    out2;
    sample_t    osc1;
    sample_t    osc2;
    slow_code_t slow_a;
    slow_code_t slow_b;
    logic       trig;
    logic [`SR_OSC_CTRL_W-1:0] osc_ctrl;

    // reference model state
    logic [31:0] lfsr;
    route_cfg_t  m_cfg;                  // mirror of the register map
    sample_t     exp_out1;
    sample_t     exp_out2;
    sample_t     exp_osc1;
    sample_t     exp_osc2;
    slow_code_t  exp_slow_a;
    slow_code_t  exp_slow_b;
    slow_code_t  slow_a_q[$];            // slow path delay line
    slow_code_t  slow_b_q[$];
    bit          rise_q[$];              // trigger delay line
    logic        prev_trig;
    logic        exp_trig;
    logic        exp_ack;
    logic        exp_rd;                 // rdata only compared after a read
    logic [31:0] exp_rdata;

    signal_router_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_in1         (in1),
        .i_in2         (in2),
        .i_ext_trigger (ext_trig),
        .i_req         (req),
        .o_rsp         (rsp),
        .o_out1        (out1),
        .o_out2        (out2),
        .o_osc1        (osc1),
        .o_osc2        (osc2),
        .o_slow_a      (slow_a),
        .o_slow_b      (slow_b),
        .o_trigger     (trig),
        .o_osc_ctrl    (osc_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns
    end

    initial begin
        #(2 * TOTAL_CYCLES * 20);
        $display("watchdog expired, the test did not finish in %0d cycles", 2 * TOTAL_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    // ---------------------------------------------------------------------------
    // random source and model rules
    // ---------------------------------------------------------------------------
    function automatic logic [31:0] galois_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rbits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_next(lfsr);  // one step per bit
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    // index 1 is in1, index 2 is in2, the rest idle
    function automatic sample_t pick(input int sel, input sample_t a, input sample_t b,
                                     input sample_t idle);
        if (sel == 1) return a;
        if (sel == 2) return b;
        return idle;
    endfunction

    function automatic slow_code_t slow_code(input sample_t s);
        int prod;
        prod = (int'(s) + `SR_SLOW_OFFSET) * `SR_SLOW_GAIN;
        return slow_code_t'(prod >> `SR_SLOW_LSB);  // keeps bits 21:10
    endfunction

    function automatic logic [31:0] sext(input sample_t s);
        return {{(32 - `SR_SAMPLE_W){s[`SR_SAMPLE_W-1]}}, s};
    endfunction

    function automatic logic [31:0] read_model(input logic [19:0] a, input route_cfg_t c,
                                               input sample_t i1, input sample_t i2,
                                               input sample_t o1, input sample_t o2,
                                               input sample_t s1, input sample_t s2,
                                               input slow_code_t d1, input slow_code_t d2);
        case (a)
            `SR_ADDR_OSC_A_SEL:  return 32'(c.osc_a_sel);
            `SR_ADDR_OSC_B_SEL:  return 32'(c.osc_b_sel);
            `SR_ADDR_OSC_CTRL:   return 32'(c.osc_ctrl);
            `SR_ADDR_TRIG_SEL:   return 32'(c.trig_sel);
            `SR_ADDR_OUT1_SEL:   return 32'(c.out1_sel);
            `SR_ADDR_OUT2_SEL:   return 32'(c.out2_sel);
            `SR_ADDR_SLOW_A_SEL: return 32'(c.slow_a_sel);
            `SR_ADDR_SLOW_B_SEL: return 32'(c.slow_b_sel);
            `SR_ADDR_IN1:        return sext(i1);
            `SR_ADDR_IN2:        return sext(i2);
            `SR_ADDR_OUT1:       return sext(o1);
            `SR_ADDR_OUT2:       return sext(o2);
            `SR_ADDR_SLOW_A:     return {20'h0, d1};
            `SR_ADDR_SLOW_B:     return {20'h0, d2};
            `SR_ADDR_OSC_A:      return sext(s1);
            `SR_ADDR_OSC_B:      return sext(s2);
            default:             return '0;  // unmapped
        endcase
    endfunction

    function automatic void write_model(input logic [19:0] a, input logic [31:0] d);
        case (a)
            `SR_ADDR_OSC_A_SEL:  m_cfg.osc_a_sel  = d[`SR_SCOPE_SEL_W-1:0];
            `SR_ADDR_OSC_B_SEL:  m_cfg.osc_b_sel  = d[`SR_SCOPE_SEL_W-1:0];
            `SR_ADDR_OSC_CTRL:   m_cfg.osc_ctrl   = d[`SR_OSC_CTRL_W-1:0];
            `SR_ADDR_TRIG_SEL:   m_cfg.trig_sel   = d[`SR_TRIG_SEL_W-1:0];
            `SR_ADDR_OUT1_SEL:   m_cfg.out1_sel   = d[`SR_OUT_SEL_W-1:0];
            `SR_ADDR_OUT2_SEL:   m_cfg.out2_sel   = d[`SR_OUT_SEL_W-1:0];
            `SR_ADDR_SLOW_A_SEL: m_cfg.slow_a_sel = d[`SR_OUT_SEL_W-1:0];
            `SR_ADDR_SLOW_B_SEL: m_cfg.slow_b_sel = d[`SR_OUT_SEL_W-1:0];
            default: ;  // read only or unmapped
        endcase
    endfunction

    // what the next rising edge does, seen from the pins
    task automatic model_edge(input sys_req_t r, input sample_t a, input sample_t b,
                              input logic t);
        route_cfg_t pre;
        bit         rise_old;
        pre       = m_cfg;
        exp_rdata = read_model(r.addr[`SR_DECODE_W-1:0], pre, a, b,
                               pick(pre.out1_sel, a, b, '0), pick(pre.out2_sel, a, b, '0),
                               exp_osc1, exp_osc2, exp_slow_a, exp_slow_b);
        exp_ack = r.wen | r.ren;
        exp_rd  = r.ren;
        if (r.wen) write_model(r.addr[`SR_DECODE_W-1:0], r.wdata);
        exp_osc1 = pick(pre.osc_a_sel, a, b, '0);   // one cycle
        exp_osc2 = pick(pre.osc_b_sel, a, b, '0);
        slow_a_q.push_back(slow_code(pick(pre.slow_a_sel, a, b, sample_t'(-`SR_SLOW_OFFSET))));
        slow_b_q.push_back(slow_code(pick(pre.slow_b_sel, a, b, sample_t'(-`SR_SLOW_OFFSET))));
        exp_slow_a = slow_a_q.pop_front();
        exp_slow_b = slow_b_q.pop_front();
        rise_q.push_back(t & ~prev_trig);
        prev_trig = t;
        rise_old  = rise_q.pop_front();             // rise seen two edges back
        exp_trig  = rise_old & (pre.trig_sel == '0);
        exp_out1  = pick(m_cfg.out1_sel, a, b, '0);  // new index acts at once
        exp_out2  = pick(m_cfg.out2_sel, a, b, '0);
    endtask

    // ---------------------------------------------------------------------------
    // checks and stimulus
    // ---------------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_outputs();
        assert (out1 === exp_out1) else report_mismatch("o_out1", out1, exp_out1);
        assert (out2 === exp_out2) else report_mismatch("o_out2", out2, exp_out2);
        assert (osc1 === exp_osc1) else report_mismatch("o_osc1", osc1, exp_osc1);
        assert (osc2 === exp_osc2) else report_mismatch("o_osc2", osc2, exp_osc2);
        assert (slow_a === exp_slow_a) else report_mismatch("o_slow_a", slow_a, exp_slow_a);
        assert (slow_b === exp_slow_b) else report_mismatch("o_slow_b", slow_b, exp_slow_b);
        assert (trig === exp_trig) else report_mismatch("o_trigger", trig, exp_trig);
        assert (osc_ctrl === m_cfg.osc_ctrl)
            else report_mismatch("o_osc_ctrl", osc_ctrl, m_cfg.osc_ctrl);
        assert (rsp.ack === exp_ack) else report_mismatch("o_rsp.ack", rsp.ack, exp_ack);
        assert (rsp.err === 1'b0) else report_mismatch("o_rsp.err", rsp.err, 0);
        if (exp_rd) begin
            assert (rsp.rdata === exp_rdata)
                else report_mismatch("o_rsp.rdata", rsp.rdata, exp_rdata);
        end
    endtask

    // check what the last edge did, drive the next cycle, wait for next falling edge
    task automatic step(input sys_req_t r, input sample_t a, input sample_t b, input logic t);
        check_outputs();
        req      = r;
        in1      = a;
        in2      = b;
        ext_trig = t;
        model_edge(r, a, b, t);
        @(negedge clk);
    endtask

    task automatic random_request(output sys_req_t r);
        logic [1:0] op;
        logic [4:0] idx;
        logic [3:0] hi;
        op  = rbits(2);
        idx = rbits(1) ? 5'(rbits(3)) : 5'(rbits(5));  // leans toward control regs
        hi  = rbits(4);                                // above the decoded bits
        r.addr  = {hi, 21'h0, idx, 2'b00};
        r.wdata = rbits(32);
        if (rbits(1)) r.wdata[7:0] = 8'(rbits(2));    // small values hit 0, 1, 2
        r.wen = (op == 2'd1);
        r.ren = op[1];
    endtask

    initial begin
        sys_req_t r;
        sample_t  a;
        sample_t  b;
        logic     t;
        lfsr     = 32'h9eca;
        rst      = 1'b1;
        in1      = '0;
        in2      = '0;
        ext_trig = 1'b0;
        req      = '0;
        m_cfg    = '0;
        m_cfg.osc_a_sel = 1;  // reset map
        m_cfg.osc_b_sel = 2;
        m_cfg.osc_ctrl  = 3;
        {exp_out1, exp_out2, exp_osc1, exp_osc2} = '0;
        {exp_slow_a, exp_slow_b} = '0;
        // one slot per scaler stage, the selector stage is the pop itself
        for (int i = 0; i < `SR_SLOW_STAGES; i++) begin
            slow_a_q.push_back('0);
            slow_b_q.push_back('0);
        end
        rise_q    = '{0, 0};
        prev_trig = 1'b0;
        exp_trig  = 1'b0;
        exp_ack   = 1'b0;
        exp_rd    = 1'b0;
        exp_rdata = '0;
        t         = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // reset values of the control registers
        for (int i = 0; i < 8; i++) begin
            r      = '0;
            r.ren  = 1'b1;
            r.addr = (i < 6) ? 32'(i * 4) : 32'(32 + (i - 6) * 4);
            step(r, '0, '0, 1'b0);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            random_request(r);
            a = sample_t'(rbits(`SR_SAMPLE_W));
            b = sample_t'(rbits(`SR_SAMPLE_W));
            if (rbits(2) == 0) t = ~t;  // slow random trigger edges
            step(r, a, b, t);
        end
        check_outputs();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* signal_router_top.sv */
`default_nettype none

`include "signal_router_cfg.svh"

module signal_router_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    // adc inputs
    input  wire signal_router_pkg::sample_t  i_in1,
    input  wire signal_router_pkg::sample_t  i_in2,
    input  wire logic                        i_ext_trigger,
    // system bus
    input  wire signal_router_pkg::sys_req_t i_req,
    output signal_router_pkg::sys_rsp_t      o_rsp,
    // fast dacs and scope channels
    output signal_router_pkg::sample_t       o_out1,
    output signal_router_pkg::sample_t       o_out2,
    output signal_router_pkg::sample_t       o_osc1,
    output signal_router_pkg::sample_t       o_osc2,
    // slow dacs
    output signal_router_pkg::slow_code_t    o_slow_a,
    output signal_router_pkg::slow_code_t    o_slow_b,
    // scope control
    output logic                             o_trigger,
    output logic [`SR_OSC_CTRL_W-1:0]        o_osc_ctrl
);

    import signal_router_pkg::*;

    route_cfg_t cfg;
    live_t      live;
    sample_t    slow_a_smp;  // registered selector out, into scaler
    sample_t    slow_b_smp;

    sys_reg_bank reg_bank_i (
        .clk    (clk),
        .rst    (rst),
        .i_req  (i_req),
        .i_live (live),
        .o_rsp  (o_rsp),
        .o_cfg  (cfg)
    );

    // ---------------------------------------------------------------------------
    // scope channels, one cycle
    // ---------------------------------------------------------------------------
    source_mux #(.SEL_W(`SR_SCOPE_SEL_W), .IDLE_VALUE('0), .REGISTERED(1'b1)) osc_a_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.osc_a_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(o_osc1)
    );

    source_mux #(.SEL_W(`SR_SCOPE_SEL_W), .IDLE_VALUE('0), .REGISTERED(1'b1)) osc_b_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.osc_b_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(o_osc2)
    );

    // ---------------------------------------------------------------------------
    // fast outputs, combinational
    // ---------------------------------------------------------------------------
    source_mux #(.SEL_W(`SR_OUT_SEL_W), .IDLE_VALUE('0), .REGISTERED(1'b0)) out1_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.out1_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(o_out1)
    );

    source_mux #(.SEL_W(`SR_OUT_SEL_W), .IDLE_VALUE('0), .REGISTERED(1'b0)) out2_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.out2_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(o_out2)
    );

    // ---------------------------------------------------------------------------
    // slow dacs, selector then scaler, four cycles total
    // ---------------------------------------------------------------------------
    // idle at most negative sample so the code sits at 0
    source_mux #(
        .SEL_W      (`SR_OUT_SEL_W),
        .IDLE_VALUE (sample_t'(-`SR_SLOW_OFFSET)),
        .REGISTERED (1'b1)
    ) slow_a_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.slow_a_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(slow_a_smp)
    );

    source_mux #(
        .SEL_W      (`SR_OUT_SEL_W),
        .IDLE_VALUE (sample_t'(-`SR_SLOW_OFFSET)),
        .REGISTERED (1'b1)
    ) slow_b_mux_i (
        .clk(clk), .rst(rst), .i_sel(cfg.slow_b_sel),
        .i_in1(i_in1), .i_in2(i_in2), .o_sample(slow_b_smp)
    );

    slow_dac_scaler slow_a_scaler_i (.clk(clk), .rst(rst), .i_sample(slow_a_smp), .o_code(o_slow_a));
    slow_dac_scaler slow_b_scaler_i (.clk(clk), .rst(rst), .i_sample(slow_b_smp), .o_code(o_slow_b));

    // external trigger to scope
    trigger_select trigger_select_i (
        .clk           (clk),
        .rst           (rst),
        .i_ext_trigger (i_ext_trigger),
        .i_sel         (cfg.trig_sel),
        .o_trigger     (o_trigger)
    );

    assign o_osc_ctrl = cfg.osc_ctrl;

    // readback of what is on the pins right now
    assign live = '{
        in1:    i_in1,
        in2:    i_in2,
        out1:   o_out1,
        out2:   o_out2,
        osc_a:  o_osc1,
        osc_b:  o_osc2,
        slow_a: o_slow_a,
        slow_b: o_slow_b
    };

endmodule

`default_nettype wire

/* trigger_select.sv */
`default_nettype none

`include "signal_router_cfg.svh"

module trigger_select (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      i_ext_trigger,  // async pin
    input  wire logic [`SR_TRIG_SEL_W-1:0] i_sel,
    output logic                           o_trigger
);

    logic [1:0] sync_q;   // two flop synchronizer
    logic       prev_q;   // last synchronized level
    logic       tick_q;
    logic       rise;
    logic       ext_sel;

    assign rise    = sync_q[1] & ~prev_q;
    assign ext_sel = (i_sel == '0);  // external pin is the only live source

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            tick_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], i_ext_trigger};
            prev_q <= sync_q[1];
            tick_q <= rise & ext_sel;  // one cycle, two edges after first seen
        end
    end

    assign o_trigger = tick_q;

endmodule

`default_nettype wire

/* slow_dac_scaler.sv */
`default_nettype none

`include "signal_router_cfg.svh"

module slow_dac_scaler (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire signal_router_pkg::sample_t i_sample,
    output signal_router_pkg::slow_code_t   o_code
);

    import signal_router_pkg::*;

    localparam int OFFS_W = 16;          // offset sample, unsigned
    localparam int PROD_W = OFFS_W + 8;  // gain fits in 8 bits

    logic [OFFS_W-1:0] offs_d;
    logic [OFFS_W-1:0] offs_q;
    logic [PROD_W-1:0] prod_q;
    slow_code_t        code_q;

    // signed sample moved to 0 .. 16383, cast sign extends first
    assign offs_d = OFFS_W'(i_sample) + OFFS_W'(`SR_SLOW_OFFSET);

    // ---------------------------------------------------------------------------
    // three stage pipe, offset, gain, slice
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offs_q <= '0;
            prod_q <= '0;
            code_q <= '0;
        end else begin
            offs_q <= offs_d;                                   // stage 1
            prod_q <= offs_q * PROD_W'(`SR_SLOW_GAIN);          // stage 2, maps to 0 .. 1.8 V
            code_q <= prod_q[`SR_SLOW_LSB +: `SR_SLOW_DAC_W];   // stage 3, bits 21:10
        end
    end

    assign o_code = code_q;

endmodule

`default_nettype wire

/* source_mux.sv */
`default_nettype none

module source_mux #(
    parameter int                         SEL_W      = 4,
    parameter signal_router_pkg::sample_t IDLE_VALUE = '0,
    parameter bit                         REGISTERED = 1'b0
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [SEL_W-1:0]           i_sel,
    input  wire signal_router_pkg::sample_t i_in1,
    input  wire signal_router_pkg::sample_t i_in2,
    output signal_router_pkg::sample_t      o_sample
);

    import signal_router_pkg::*;

    sample_t sel_d;

    // only in1 and in2 exist as sources, the rest park at idle
    always_comb begin
        case (i_sel)
            SEL_W'(1): sel_d = i_in1;
            SEL_W'(2): sel_d = i_in2;
            default:   sel_d = IDLE_VALUE;
        endcase
    end

    generate
        if (REGISTERED) begin : g_reg
            // one cycle latency, comes out of reset at idle
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    o_sample <= IDLE_VALUE;
                end else begin
                    o_sample <= sel_d;
                end
            end
        end else begin : g_comb
            assign o_sample = sel_d;  // zero latency path
        end
    endgenerate

endmodule

`default_nettype wire

/* sys_reg_bank.sv */
`default_nettype none

`include "signal_router_cfg.svh"

module sys_reg_bank (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire signal_router_pkg::sys_req_t   i_req,
    input  wire signal_router_pkg::live_t      i_live,
    output signal_router_pkg::sys_rsp_t        o_rsp,
    output signal_router_pkg::route_cfg_t      o_cfg
);

    import signal_router_pkg::*;

    // scope A on in1, scope B on in2, both filters off
    localparam route_cfg_t CFG_RESET = '{
        osc_a_sel: `SR_SCOPE_SEL_W'(1),
        osc_b_sel: `SR_SCOPE_SEL_W'(2),
        osc_ctrl:  `SR_OSC_CTRL_W'(3),
        default:   '0
    };

    logic [`SR_DECODE_W-1:0] addr;   // decoded part of the bus address
    route_cfg_t              cfg_q;
    logic [`SR_BUS_W-1:0]    rdata_d;
    logic [`SR_BUS_W-1:0]    rdata_q;
    logic                    ack_q;

    assign addr = i_req.addr[`SR_DECODE_W-1:0];

    // ---------------------------------------------------------------------------
    // write side
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_q <= CFG_RESET;
        end else if (i_req.wen) begin
            case (addr)
                `SR_ADDR_OSC_A_SEL:  cfg_q.osc_a_sel  <= i_req.wdata[`SR_SCOPE_SEL_W-1:0];
                `SR_ADDR_OSC_B_SEL:  cfg_q.osc_b_sel  <= i_req.wdata[`SR_SCOPE_SEL_W-1:0];
                `SR_ADDR_OSC_CTRL:   cfg_q.osc_ctrl   <= i_req.wdata[`SR_OSC_CTRL_W-1:0];
                `SR_ADDR_TRIG_SEL:   cfg_q.trig_sel   <= i_req.wdata[`SR_TRIG_SEL_W-1:0];
                `SR_ADDR_OUT1_SEL:   cfg_q.out1_sel   <= i_req.wdata[`SR_OUT_SEL_W-1:0];
                `SR_ADDR_OUT2_SEL:   cfg_q.out2_sel   <= i_req.wdata[`SR_OUT_SEL_W-1:0];
                `SR_ADDR_SLOW_A_SEL: cfg_q.slow_a_sel <= i_req.wdata[`SR_OUT_SEL_W-1:0];
                `SR_ADDR_SLOW_B_SEL: cfg_q.slow_b_sel <= i_req.wdata[`SR_OUT_SEL_W-1:0];
                default: ;  // live and unmapped writes dropped
            endcase
        end
    end

    assign o_cfg = cfg_q;

    // ---------------------------------------------------------------------------
    // read side
    // ---------------------------------------------------------------------------
    // indices and codes zero extend while samples sign extend in the cast
    always_comb begin
        case (addr)
            `SR_ADDR_OSC_A_SEL:  rdata_d = `SR_BUS_W'(cfg_q.osc_a_sel);
            `SR_ADDR_OSC_B_SEL:  rdata_d = `SR_BUS_W'(cfg_q.osc_b_sel);
            `SR_ADDR_OSC_CTRL:   rdata_d = `SR_BUS_W'(cfg_q.osc_ctrl);
            `SR_ADDR_TRIG_SEL:   rdata_d = `SR_BUS_W'(cfg_q.trig_sel);
            `SR_ADDR_OUT1_SEL:   rdata_d = `SR_BUS_W'(cfg_q.out1_sel);
            `SR_ADDR_OUT2_SEL:   rdata_d = `SR_BUS_W'(cfg_q.out2_sel);
            `SR_ADDR_SLOW_A_SEL: rdata_d = `SR_BUS_W'(cfg_q.slow_a_sel);
            `SR_ADDR_SLOW_B_SEL: rdata_d = `SR_BUS_W'(cfg_q.slow_b_sel);
            `SR_ADDR_IN1:        rdata_d = `SR_BUS_W'(i_live.in1);    // signed
            `SR_ADDR_IN2:        rdata_d = `SR_BUS_W'(i_live.in2);
            `SR_ADDR_OUT1:       rdata_d = `SR_BUS_W'(i_live.out1);
            `SR_ADDR_OUT2:       rdata_d = `SR_BUS_W'(i_live.out2);
            `SR_ADDR_SLOW_A:     rdata_d = `SR_BUS_W'(i_live.slow_a); // unsigned
            `SR_ADDR_SLOW_B:     rdata_d = `SR_BUS_W'(i_live.slow_b);
            `SR_ADDR_OSC_A:      rdata_d = `SR_BUS_W'(i_live.osc_a);
            `SR_ADDR_OSC_B:      rdata_d = `SR_BUS_W'(i_live.osc_b);
            default:             rdata_d = '0;
        endcase
    end

    // every strobe answered one cycle later with no wait states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            rdata_q <= rdata_d;  // live values as seen at the request edge
            ack_q   <= i_req.wen | i_req.ren;
        end
    end

    assign o_rsp = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

endmodule

`default_nettype wire

/* signal_router_pkg.sv */
`default_nettype none

`include "signal_router_cfg.svh"

package signal_router_pkg;

    // samples and codes
    typedef logic signed [`SR_SAMPLE_W-1:0] sample_t;    // -8192 .. 8191
    typedef logic        [`SR_SLOW_DAC_W-1:0] slow_code_t; // 0 .. 4095

    // ---------------------------------------------------------------------------
    // system bus
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic [`SR_BUS_W-1:0] addr;
        logic [`SR_BUS_W-1:0] wdata;
        logic                 wen;   // one cycle write strobe
        logic                 ren;   // one cycle read strobe
    } sys_req_t;

    typedef struct packed {
        logic [`SR_BUS_W-1:0] rdata;
        logic                 err;   // never set
        logic                 ack;   // one cycle after strobe
    } sys_rsp_t;

    // control registers as seen by the datapath
    typedef struct packed {
        logic [`SR_SCOPE_SEL_W-1:0] osc_a_sel;
        logic [`SR_SCOPE_SEL_W-1:0] osc_b_sel;
        logic [`SR_OSC_CTRL_W-1:0]  osc_ctrl;
        logic [`SR_TRIG_SEL_W-1:0]  trig_sel;
        logic [`SR_OUT_SEL_W-1:0]   out1_sel;
        logic [`SR_OUT_SEL_W-1:0]   out2_sel;
        logic [`SR_OUT_SEL_W-1:0]   slow_a_sel;
        logic [`SR_OUT_SEL_W-1:0]   slow_b_sel;
    } route_cfg_t;

    // live values for readback
    typedef struct packed {
        sample_t    in1;
        sample_t    in2;
        sample_t    out1;
        sample_t    out2;
        sample_t    osc_a;
        sample_t    osc_b;
        slow_code_t slow_a;
        slow_code_t slow_b;
    } live_t;

endpackage

`default_nettype wire

/* signal_router_cfg.svh */
`ifndef SIGNAL_ROUTER_CFG_SVH
`define SIGNAL_ROUTER_CFG_SVH

// datapath widths
`define SR_SAMPLE_W     14  // fast adc/dac sample
`define SR_SLOW_DAC_W   12  // slow dac code
`define SR_SCOPE_SEL_W  5   // scope channel index
`define SR_OUT_SEL_W    4   // fast and slow output index
`define SR_TRIG_SEL_W   8   // trigger source index
`define SR_OSC_CTRL_W   2   // [osc2_filt_off, osc1_filt_off]

// system bus
`define SR_BUS_W        32
`define SR_DECODE_W     20  // low address bits used for decode

// slow dac mapping, sample + offset, times gain, keep bits from lsb up
`define SR_SLOW_OFFSET  8192
`define SR_SLOW_GAIN    156
`define SR_SLOW_LSB     10
`define SR_SLOW_STAGES  3   // scaler latency in cycles

// ---------------------------------------------------------------------------
// register map
// ---------------------------------------------------------------------------
`define SR_ADDR_OSC_A_SEL   20'h00000
`define SR_ADDR_OSC_B_SEL   20'h00004
`define SR_ADDR_OSC_CTRL    20'h00008
`define SR_ADDR_TRIG_SEL    20'h0000C
`define SR_ADDR_OUT1_SEL    20'h00010
`define SR_ADDR_OUT2_SEL    20'h00014
`define SR_ADDR_SLOW_A_SEL  20'h00020
`define SR_ADDR_SLOW_B_SEL  20'h00024
`define SR_ADDR_IN1         20'h00028  // live, read only from here down
`define SR_ADDR_IN2         20'h0002C
`define SR_ADDR_OUT1        20'h00030
`define SR_ADDR_OUT2        20'h00034
`define SR_ADDR_SLOW_A      20'h00040
`define SR_ADDR_SLOW_B      20'h00044
`define SR_ADDR_OSC_A       20'h00048
`define SR_ADDR_OSC_B       20'h0004C

`endif
